/* hw/stream_route_pkg.sv */
// ==============================
// Shared types and constants for the two-way stream router
// The beat struct is 23 bits and must match on every stream port
// Wishbone words are 16 bits wide with four word addresses
// Counter width equals the Wishbone data width so counts read back whole
// ==============================

package stream_route_pkg;

    localparam int DATA_WIDTH    = 16;
    localparam int USER_WIDTH    = 4;
    localparam int DEST_WIDTH    = 2;
    localparam int COUNT_WIDTH   = 16;
    localparam int WB_ADDR_WIDTH = 2;
    localparam int WB_DATA_WIDTH = 16;

    // Register word addresses
    localparam logic [WB_ADDR_WIDTH-1:0] ADDR_CTRL   = 2'd0;
    localparam logic [WB_ADDR_WIDTH-1:0] ADDR_STATUS = 2'd1;
    localparam logic [WB_ADDR_WIDTH-1:0] ADDR_COUNT0 = 2'd2;
    localparam logic [WB_ADDR_WIDTH-1:0] ADDR_COUNT1 = 2'd3;

    // Bit positions in the control word
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_SELECT_BIT = 1;

    // One stream beat with its side-band fields
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [DEST_WIDTH-1:0] dest;
        logic [USER_WIDTH-1:0] user;
        logic                  last;
    } stream_beat_t;

    // Wishbone classic request from the master
    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [WB_ADDR_WIDTH-1:0] adr;
        logic [WB_DATA_WIDTH-1:0] dat_w;
    } wb_req_t;

    // Wishbone classic response from the slave
    typedef struct packed {
        logic                     ack;
        logic [WB_DATA_WIDTH-1:0] dat_r;
    } wb_rsp_t;

    // Routing configuration as written by software
    typedef struct packed {
        logic enable;
        logic select;
    } route_cfg_t;

    typedef enum logic {
        IDLE   = 1'b0,
        PACKET = 1'b1
    } route_state_t;

endpackage

/* hw/packet_counter.sv */
// ==============================
// Delivered packet counters, one per output
// Counts saturate at all ones until cleared
// A clear in the same cycle as a done pulse wins
// ==============================

`timescale 1ns/1ps

module packet_counter (
    input  logic                                       clock,
    input  logic                                       rst_n,
    input  logic                                       done0,
    input  logic                                       done1,
    input  logic                                       clear0,
    input  logic                                       clear1,
    output logic [stream_route_pkg::COUNT_WIDTH-1:0]   count0,
    output logic [stream_route_pkg::COUNT_WIDTH-1:0]   count1
);

    logic [1:0]                                done;
    logic [1:0]                                clear;
    logic [stream_route_pkg::COUNT_WIDTH-1:0]  count_q [2];

    assign done  = {done1, done0};
    assign clear = {clear1, clear0};

    for (genvar i = 0; i < 2; i++) begin : gen_count
        always_ff @(posedge clock or negedge rst_n) begin
            if (!rst_n) begin
                count_q[i] <= '0;
            end else if (clear[i]) begin
                count_q[i] <= '0;
            end else if (done[i] && (count_q[i] != '1)) begin
                count_q[i] <= count_q[i] + 1'b1;
            end
        end
    end

    assign count0 = count_q[0];
    assign count1 = count_q[1];

endmodule

/* hw/stream_selector.sv */
// ==============================
// Registered one-to-two stream selector
// Each output has its own holding register, so both may hold a beat
// Input ready follows the granted output only
// Dest is carried along and does not steer the beat
// ==============================

`timescale 1ns/1ps

module stream_selector (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           grant,
    input  logic                           active_select,
    input  logic                           s_valid,
    input  stream_route_pkg::stream_beat_t s_beat,
    output logic                           s_ready,
    output logic                           m0_valid,
    output stream_route_pkg::stream_beat_t m0_beat,
    input  logic                           m0_ready,
    output logic                           m1_valid,
    output stream_route_pkg::stream_beat_t m1_beat,
    input  logic                           m1_ready,
    output logic                           in_last_accepted,
    output logic                           done0,
    output logic                           done1
);

    logic [1:0]                     hold_valid;
    stream_route_pkg::stream_beat_t hold_beat [2];
    logic [1:0]                     out_ready;
    logic [1:0]                     can_take;
    logic [1:0]                     load;
    logic [1:0]                     leave_last;
    logic                           accept;

    assign out_ready = {m1_ready, m0_ready};

    // A register can take a beat when empty or draining in this cycle
    assign can_take = ~hold_valid | out_ready;
    assign s_ready  = grant && can_take[active_select];
    assign accept   = s_valid && s_ready;
    assign load     = {accept && active_select, accept && !active_select};

    assign in_last_accepted = accept && s_beat.last;

    for (genvar i = 0; i < 2; i++) begin : gen_hold
        always_ff @(posedge clock or negedge rst_n) begin
            if (!rst_n) begin
                hold_valid[i] <= 1'b0;
            end else if (load[i]) begin
                hold_valid[i] <= 1'b1;
            end else if (out_ready[i]) begin
                hold_valid[i] <= 1'b0;
            end
        end

        always_ff @(posedge clock) begin
            if (load[i]) begin
                hold_beat[i] <= s_beat;
            end
        end

        assign leave_last[i] = hold_valid[i] && out_ready[i] && hold_beat[i].last;

        held_beat_stable: assert property (
            @(posedge clock) disable iff (!rst_n)
            hold_valid[i] && !out_ready[i] |=> hold_valid[i] && $stable(hold_beat[i])
        ) else $error("Output %0d changed a stalled beat", i);
    end

    assign m0_valid = hold_valid[0];
    assign m0_beat  = hold_beat[0];
    assign m1_valid = hold_valid[1];
    assign m1_beat  = hold_beat[1];
    assign done0    = leave_last[0];
    assign done1    = leave_last[1];

    // Between packets the input must stay closed
    no_ready_without_grant: assert property (
        @(posedge clock) disable iff (!rst_n)
        !grant |-> !s_ready
    ) else $error("Input ready raised without grant");

endmodule

/* hw/route_ctrl_fsm.sv */
// ==============================
// Packet boundary control for the router
// The destination is sampled only when a packet starts
// A select change in mid-packet applies to the next packet
// Clearing enable lets the current packet finish
// ==============================

`timescale 1ns/1ps

module route_ctrl_fsm (
    input  logic                           clock,
    input  logic                           rst_n,
    input  stream_route_pkg::route_cfg_t   cfg,
    input  logic                           s_valid,
    input  logic                           in_last_accepted,
    output logic                           grant,
    output logic                           active_select,
    output logic                           busy
);

    stream_route_pkg::route_state_t state;
    stream_route_pkg::route_state_t state_next;
    logic                           start;

    // A packet may only start from idle with the router enabled
    assign start = (state == stream_route_pkg::IDLE) && s_valid && cfg.enable;

    always_comb begin
        state_next = state;
        case (state)
            stream_route_pkg::IDLE: begin
                if (start) begin
                    state_next = stream_route_pkg::PACKET;
                end
            end
            stream_route_pkg::PACKET: begin
                // The last beat closes the packet on the edge it is taken
                if (in_last_accepted) begin
                    state_next = stream_route_pkg::IDLE;
                end
            end
            default: state_next = stream_route_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state         <= stream_route_pkg::IDLE;
            active_select <= 1'b0;
        end else begin
            state <= state_next;
            if (start) begin
                active_select <= cfg.select;
            end
        end
    end

    // Input is granted for the whole packet and nowhere else
    assign grant = (state == stream_route_pkg::PACKET);
    assign busy  = (state == stream_route_pkg::PACKET);

    // A packet must leave through one output only
    select_stable_in_packet: assert property (
        @(posedge clock) disable iff (!rst_n)
        (state == stream_route_pkg::PACKET) |=> $stable(active_select)
    ) else $error("Active select changed inside a packet");

endmodule

/* hw/route_regs.sv */
// ==============================
// Wishbone classic register block for the router
// Single cycles only, no bursts and no error response
// Ack follows one cycle after cyc and stb, and never two in a row
// Any write to a count address clears that count and its data is ignored
// STATUS is read-only and writes to it are acknowledged and dropped
// ==============================

`timescale 1ns/1ps

module route_regs (
    input  logic                                          clock,
    input  logic                                          rst_n,
    input  stream_route_pkg::wb_req_t                     wb_req,
    output stream_route_pkg::wb_rsp_t                     wb_rsp,
    output stream_route_pkg::route_cfg_t                  cfg,
    input  logic                                          busy,
    input  logic                                          active_select,
    input  logic [stream_route_pkg::COUNT_WIDTH-1:0]      count0,
    input  logic [stream_route_pkg::COUNT_WIDTH-1:0]      count1,
    output logic                                          clear0,
    output logic                                          clear1
);

    logic                                         ack_q;
    logic [stream_route_pkg::WB_DATA_WIDTH-1:0]   dat_r_q;
    logic [stream_route_pkg::WB_DATA_WIDTH-1:0]   rd_data;
    logic                                         access;

    // A new access is one that has not been acknowledged yet
    assign access = wb_req.cyc && wb_req.stb && !ack_q;

    always_comb begin
        rd_data = '0;
        case (wb_req.adr)
            stream_route_pkg::ADDR_CTRL: begin
                rd_data[stream_route_pkg::CTRL_ENABLE_BIT] = cfg.enable;
                rd_data[stream_route_pkg::CTRL_SELECT_BIT] = cfg.select;
            end
            stream_route_pkg::ADDR_STATUS: begin
                rd_data[0] = busy;
                rd_data[1] = active_select;
            end
            stream_route_pkg::ADDR_COUNT0: rd_data = count0;
            stream_route_pkg::ADDR_COUNT1: rd_data = count1;
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ack_q  <= 1'b0;
            cfg    <= '0;
            clear0 <= 1'b0;
            clear1 <= 1'b0;
        end else begin
            ack_q  <= access;
            // Clear pulses line up with the ack of the write
            clear0 <= access && wb_req.we && (wb_req.adr == stream_route_pkg::ADDR_COUNT0);
            clear1 <= access && wb_req.we && (wb_req.adr == stream_route_pkg::ADDR_COUNT1);
            if (access && wb_req.we && (wb_req.adr == stream_route_pkg::ADDR_CTRL)) begin
                cfg.enable <= wb_req.dat_w[stream_route_pkg::CTRL_ENABLE_BIT];
                cfg.select <= wb_req.dat_w[stream_route_pkg::CTRL_SELECT_BIT];
            end
        end
    end

    // Read data is captured when a read is first seen and held through its ack
    always_ff @(posedge clock) begin
        if (access && !wb_req.we) begin
            dat_r_q <= rd_data;
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_r_q;

    // The master must see a low ack between accesses
    ack_single_cycle: assert property (
        @(posedge clock) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack
    ) else $error("Wishbone ack held high for two cycles");

endmodule

/* hw/stream_router_top.sv */
// ==============================
// Packet-aware two-way stream router
// One input stream, two output streams, Wishbone classic control
// A packet always leaves on a single output
// ==============================

`timescale 1ns/1ps

module stream_router_top (
    input  logic                           clock,
    input  logic                           rst_n,
    input  stream_route_pkg::wb_req_t      wb_req,
    output stream_route_pkg::wb_rsp_t      wb_rsp,
    input  logic                           s_valid,
    input  stream_route_pkg::stream_beat_t s_beat,
    output logic                           s_ready,
    output logic                           m0_valid,
    output stream_route_pkg::stream_beat_t m0_beat,
    input  logic                           m0_ready,
    output logic                           m1_valid,
    output stream_route_pkg::stream_beat_t m1_beat,
    input  logic                           m1_ready
);

    stream_route_pkg::route_cfg_t               cfg;
    logic                                       grant;
    logic                                       active_select;
    logic                                       busy;
    logic                                       in_last_accepted;
    logic                                       done0;
    logic                                       done1;
    logic                                       clear0;
    logic                                       clear1;
    logic [stream_route_pkg::COUNT_WIDTH-1:0]   count0;
    logic [stream_route_pkg::COUNT_WIDTH-1:0]   count1;

    route_regs route_regs_inst (
        .clock         (clock),
        .rst_n         (rst_n),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .cfg           (cfg),
        .busy          (busy),
        .active_select (active_select),
        .count0        (count0),
        .count1        (count1),
        .clear0        (clear0),
        .clear1        (clear1)
    );

    route_ctrl_fsm route_ctrl_fsm_inst (
        .clock            (clock),
        .rst_n            (rst_n),
        .cfg              (cfg),
        .s_valid          (s_valid),
        .in_last_accepted (in_last_accepted),
        .grant            (grant),
        .active_select    (active_select),
        .busy             (busy)
    );

    packet_counter packet_counter_inst (
        .clock  (clock),
        .rst_n  (rst_n),
        .done0  (done0),
        .done1  (done1),
        .clear0 (clear0),
        .clear1 (clear1),
        .count0 (count0),
        .count1 (count1)
    );

    stream_selector stream_selector_inst (
        .clock            (clock),
        .rst_n            (rst_n),
        .grant            (grant),
        .active_select    (active_select),
        .s_valid          (s_valid),
        .s_beat           (s_beat),
        .s_ready          (s_ready),
        .m0_valid         (m0_valid),
        .m0_beat          (m0_beat),
        .m0_ready         (m0_ready),
        .m1_valid         (m1_valid),
        .m1_beat          (m1_beat),
        .m1_ready         (m1_ready),
        .in_last_accepted (in_last_accepted),
        .done0            (done0),
        .done1            (done1)
    );

endmodule

/* dv/stream_router_checker.sv */
// ==============================
// Scoreboard for the stream router testbench
// Learns enable and select from the Wishbone writes seen on the bus
// A packet goes to the select seen when its first beat is accepted
// Expects single Wishbone accesses with the request held until ack
// ==============================

`timescale 1ns/1ps

module stream_router_checker (
    input  logic                           clock,
    input  logic                           rst_n,
    input  stream_route_pkg::wb_req_t      wb_req,
    input  stream_route_pkg::wb_rsp_t      wb_rsp,
    input  logic                           s_valid,
    input  stream_route_pkg::stream_beat_t s_beat,
    input  logic                           s_ready,
    input  logic                           m0_valid,
    input  stream_route_pkg::stream_beat_t m0_beat,
    input  logic                           m0_ready,
    input  logic                           m1_valid,
    input  stream_route_pkg::stream_beat_t m1_beat,
    input  logic                           m1_ready,
    input  logic [15:0]                    exp_dat,
    input  logic                           exp_check,
    input  logic                           end_check,
    output int                             errors
);

    stream_route_pkg::stream_beat_t           q0 [$];
    stream_route_pkg::stream_beat_t           q1 [$];
    logic [stream_route_pkg::COUNT_WIDTH-1:0] count0;
    logic [stream_route_pkg::COUNT_WIDTH-1:0] count1;
    logic                                     cfg_enable;
    logic                                     cfg_select;
    logic                                     in_pkt;
    logic                                     pkt_sel;

    initial errors = 0;

    task automatic check_output(input int port, input stream_route_pkg::stream_beat_t got);
        stream_route_pkg::stream_beat_t want;
        if ((port == 0) ? (q0.size() == 0) : (q1.size() == 0)) begin
            $display("Unexpected beat on output %0d at %0t ns, no packet routed there",
                     port, $time);
            errors++;
        end else begin
            want = (port == 0) ? q0.pop_front() : q1.pop_front();
            if (got !== want) begin
                $display("MISMATCH at %0t ns: output %0d beat %h, expected %h",
                         $time, port, got, want);
                errors++;
            end
            // A packet is counted once its last beat has left
            if (want.last) begin
                if (port == 0) count0 = count0 + 1'b1;
                else count1 = count1 + 1'b1;
            end
        end
    endtask

    task automatic check_read(input logic [1:0] adr, input logic [15:0] got);
        if (exp_check && got !== exp_dat) begin
            $display("MISMATCH at %0t ns: register %0d read %h, expected %h",
                     $time, adr, got, exp_dat);
            errors++;
        end
        if ((adr == stream_route_pkg::ADDR_COUNT0 && got !== count0) ||
            (adr == stream_route_pkg::ADDR_COUNT1 && got !== count1)) begin
            $display("MISMATCH at %0t ns: count register %0d read %0d, model has %0d and %0d",
                     $time, adr, got, count0, count1);
            errors++;
        end
    endtask

    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            q0.delete();
            q1.delete();
            count0     = '0;
            count1     = '0;
            cfg_enable = 1'b0;
            cfg_select = 1'b0;
            in_pkt     = 1'b0;
            pkt_sel    = 1'b0;
        end else begin
            // Outputs are checked first since a beat taken at this edge cannot leave at it
            if (m0_valid && m0_ready) check_output(0, m0_beat);
            if (m1_valid && m1_ready) check_output(1, m1_beat);
            if (s_ready && !in_pkt && !cfg_enable) begin
                $display("Input ready high at %0t ns while the router is disabled and idle", $time);
                errors++;
            end
            if (s_valid && s_ready) begin
                if (!in_pkt) begin
                    pkt_sel = cfg_select;
                    in_pkt  = 1'b1;
                end
                if (pkt_sel) q1.push_back(s_beat);
                else q0.push_back(s_beat);
                if (s_beat.last) in_pkt = 1'b0;
            end
            // Register writes land after the input, so a started packet keeps its output
            if (wb_req.cyc && wb_req.stb && wb_rsp.ack) begin
                if (!wb_req.we) begin
                    check_read(wb_req.adr, wb_rsp.dat_r);
                end else if (wb_req.adr == stream_route_pkg::ADDR_CTRL) begin
                    cfg_enable = wb_req.dat_w[stream_route_pkg::CTRL_ENABLE_BIT];
                    cfg_select = wb_req.dat_w[stream_route_pkg::CTRL_SELECT_BIT];
                end else if (wb_req.adr == stream_route_pkg::ADDR_COUNT0) begin
                    count0 = '0;
                end else if (wb_req.adr == stream_route_pkg::ADDR_COUNT1) begin
                    count1 = '0;
                end
            end
        end
    end

    always @(posedge end_check) begin
        if (q0.size() != 0 || q1.size() != 0) begin
            $display("Beats never delivered at end of run: %0d for output 0, %0d for output 1",
                     q0.size(), q1.size());
            errors++;
        end
    end

endmodule

/* dv/stream_router_tb.sv */
// ==============================
// Testbench for the two-way stream router
// Runs a fixed table of register accesses and packet sends
// Payload and back-pressure come from $random with seed 95
// All comparing is done in stream_router_checker
// ==============================

`timescale 1ns/1ps

module stream_router_tb;

    typedef enum logic [1:0] {WB_WRITE, WB_READ, SEND} entry_kind_t;

    // Data is write data, or the expected value of a read
    typedef struct packed {
        entry_kind_t kind;
        logic [1:0]  adr;
        logic [15:0] data;
        logic [7:0]  len;
        logic        bp0;
        logic        bp1;
        logic        mid_wr;
        logic [15:0] mid_data;
    } entry_t;

    logic                           clock;
    logic                           rst_n;
    stream_route_pkg::wb_req_t      wb_req;
    stream_route_pkg::wb_rsp_t      wb_rsp;
    logic                           s_valid;
    stream_route_pkg::stream_beat_t s_beat;
    logic                           s_ready;
    logic                           m0_valid;
    stream_route_pkg::stream_beat_t m0_beat;
    logic                           m0_ready;
    logic                           m1_valid;
    stream_route_pkg::stream_beat_t m1_beat;
    logic                           m1_ready;
    logic [15:0]                    exp_dat;
    logic                           exp_check;
    logic                           end_check;
    logic                           bp0;
    logic                           bp1;
    int                             errors;
    int                             cycles;
    int                             limit;
    integer                         seed = 95;
    entry_t                         stim [$];

    stream_router_top stream_router_top_inst (.*);
    stream_router_checker checker_inst (.*);

    always #5 clock = ~clock;

    // Readies settle a little after the payload so the random draws keep one order
    always @(posedge clock) begin
        #2;
        m0_ready = bp0 ? $random(seed) : 1'b1;
        m1_ready = bp1 ? $random(seed) : 1'b1;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic entry_t write_entry(input logic [1:0] adr, input logic [15:0] data);
        return {WB_WRITE, adr, data, 8'd0, 3'b000, 16'h0000};
    endfunction

    function automatic entry_t read_entry(input logic [1:0] adr, input logic [15:0] data);
        return {WB_READ, adr, data, 8'd0, 3'b000, 16'h0000};
    endfunction

    function automatic entry_t packet_entry(input logic [7:0] len, input logic bp_0,
                                            input logic bp_1, input logic mid_wr,
                                            input logic [15:0] mid_data);
        return {SEND, 2'd0, 16'h0000, len, bp_0, bp_1, mid_wr, mid_data};
    endfunction

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [15:0] data);
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = data;
        @(posedge clock);
        while (!wb_rsp.ack) @(posedge clock);
        #1;
        wb_req = '0;
        // One idle cycle before the next access
        @(posedge clock);
        #1;
    endtask

    task automatic send_packet(input int len);
        for (int i = 0; i < len; i++) begin
            s_beat.data = $random(seed);
            s_beat.dest = $random(seed);
            s_beat.user = $random(seed);
            s_beat.last = (i == len - 1);
            s_valid     = 1'b1;
            @(posedge clock);
            while (!s_ready) @(posedge clock);
            #1;
        end
        s_valid = 1'b0;
    endtask

    task automatic run_entry(input entry_t e);
        case (e.kind)
            WB_WRITE: wb_access(1'b1, e.adr, e.data);
            WB_READ: begin
                exp_dat   = e.data;
                exp_check = 1'b1;
                wb_access(1'b0, e.adr, 16'h0000);
                exp_check = 1'b0;
            end
            SEND: begin
                bp0 = e.bp0;
                bp1 = e.bp1;
                fork
                    send_packet(e.len);
                    if (e.mid_wr) begin
                        repeat (8) @(posedge clock);
                        #1;
                        wb_access(1'b1, stream_route_pkg::ADDR_CTRL, e.mid_data);
                    end
                join
                // Both holding registers drain before the next entry starts
                while (m0_valid || m1_valid) @(posedge clock);
                #1;
                bp0 = 1'b0;
                bp1 = 1'b0;
            end
        endcase
    endtask

    initial begin
        int err_before;
        int failed;
        clock = 1'b0;
        rst_n = 1'b0;
        wb_req = '0;
        s_valid = 1'b0;
        s_beat = '0;
        m0_ready = 1'b1;
        m1_ready = 1'b1;
        bp0 = 1'b0;
        bp1 = 1'b0;
        exp_dat = '0;
        exp_check = 1'b0;
        end_check = 1'b0;
        cycles = 0;
        failed = 0;
        // Select 0, then select 1, then a select change in mid-packet
        stim.push_back(write_entry(stream_route_pkg::ADDR_CTRL, 16'h0001));
        stim.push_back(packet_entry(8'd4, 1'b0, 1'b0, 1'b0, 16'h0000));
        stim.push_back(packet_entry(8'd6, 1'b0, 1'b0, 1'b0, 16'h0000));
        stim.push_back(read_entry(stream_route_pkg::ADDR_STATUS, 16'h0000));
        stim.push_back(write_entry(stream_route_pkg::ADDR_CTRL, 16'h0003));
        stim.push_back(packet_entry(8'd5, 1'b0, 1'b0, 1'b0, 16'h0000));
        stim.push_back(packet_entry(8'd12, 1'b0, 1'b0, 1'b1, 16'h0001));
        stim.push_back(packet_entry(8'd3, 1'b0, 1'b0, 1'b0, 16'h0000));
        // Random back-pressure on one output, then on both
        stim.push_back(packet_entry(8'd8, 1'b1, 1'b0, 1'b0, 16'h0000));
        stim.push_back(write_entry(stream_route_pkg::ADDR_CTRL, 16'h0003));
        stim.push_back(packet_entry(8'd10, 1'b0, 1'b1, 1'b0, 16'h0000));
        stim.push_back(packet_entry(8'd7, 1'b1, 1'b1, 1'b1, 16'h0001));
        stim.push_back(packet_entry(8'd4, 1'b1, 1'b1, 1'b0, 16'h0000));
        // Disabled router holds the packet until enable returns
        stim.push_back(write_entry(stream_route_pkg::ADDR_CTRL, 16'h0000));
        stim.push_back(packet_entry(8'd5, 1'b0, 1'b0, 1'b1, 16'h0003));
        stim.push_back(read_entry(stream_route_pkg::ADDR_COUNT0, 16'd5));
        stim.push_back(read_entry(stream_route_pkg::ADDR_COUNT1, 16'd5));
        stim.push_back(write_entry(stream_route_pkg::ADDR_COUNT0, 16'hffff));
        stim.push_back(read_entry(stream_route_pkg::ADDR_COUNT0, 16'd0));
        stim.push_back(read_entry(stream_route_pkg::ADDR_COUNT1, 16'd5));
        stim.push_back(write_entry(stream_route_pkg::ADDR_COUNT1, 16'h0000));
        stim.push_back(read_entry(stream_route_pkg::ADDR_COUNT1, 16'd0));
        stim.push_back(read_entry(stream_route_pkg::ADDR_STATUS, 16'h0002));
        stim.push_back(read_entry(stream_route_pkg::ADDR_CTRL, 16'h0003));
        limit = 200;
        foreach (stim[i]) begin
            limit += 4 * ((stim[i].kind == SEND) ? (stim[i].len + stim[i].mid_wr) : 1);
        end
        repeat (5) @(posedge clock);
        #1;
        rst_n = 1'b1;
        foreach (stim[i]) begin
            err_before = errors;
            run_entry(stim[i]);
            $display("Entry %0d kind %0d adr %0d: %s", i, stim[i].kind, stim[i].adr,
                     (errors == err_before) ? "ok" : "FAILED");
            if (errors != err_before) failed++;
        end
        end_check = 1'b1;
        #1;
        $display("Summary: %0d entries, %0d failed, %0d errors", stim.size(), failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* sources.f */
hw/stream_route_pkg.sv
hw/packet_counter.sv
hw/stream_selector.sv
hw/route_ctrl_fsm.sv
hw/route_regs.sv
hw/stream_router_top.sv
dv/stream_router_checker.sv
dv/stream_router_tb.sv

/* Bender.yml */
package:
  name: stream_router

sources:
  - hw/stream_route_pkg.sv
  - hw/packet_counter.sv
  - hw/stream_selector.sv
  - hw/route_ctrl_fsm.sv
  - hw/route_regs.sv
  - hw/stream_router_top.sv
  - target: test
    files:
      - dv/stream_router_checker.sv
      - dv/stream_router_tb.sv
